//--- Bender.yml
package:
  name: issue_block

export_include_dirs:
  - .

sources:
  - issue_pkg.sv
  - stage_reg.sv
  - issue_queue.sv
  - pair_hazard.sv
  - issue_stage.sv
  - register_file.sv
  - issue_top.sv
  - target: test
    files:
      - issue_props.sv
      - tb_issue_top.sv

//--- build.f
+incdir+.
issue_pkg.sv
stage_reg.sv
issue_queue.sv
pair_hazard.sv
issue_stage.sv
register_file.sv
issue_top.sv
issue_props.sv
tb_issue_top.sv

//--- issue_cfg.svh
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// integer register count, x0 included
`define ISSUE_NREGS 32

// register data width
`define ISSUE_XLEN 32

// in-order queue depth, counted in instruction pairs
`define ISSUE_QDEPTH 8

`endif

//--- issue_pkg.sv
`include "issue_cfg.svh"

package issue_pkg;

  typedef logic [$clog2(`ISSUE_NREGS)-1:0] reg_addr_t;
  typedef logic [`ISSUE_XLEN-1:0] xdata_t;

  // nop sits at zero so that a cleared op decodes as nop
  typedef enum logic [2:0] {
    op_nop    = 3'd0,
    op_alu    = 3'd1,
    op_load   = 3'd2,
    op_store  = 3'd3,
    op_branch = 3'd4
  } op_kind_t;

  typedef struct packed {
    logic      valid;
    op_kind_t  kind;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      rden1;
    logic      rden2;
    logic      wren;
    logic [2:0] tag;
  } micro_op_t;

  typedef struct packed {
    micro_op_t slot0;
    micro_op_t slot1;
  } pair_t;

  // load issued last cycle, still in execute
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
  } load_tag_t;

  localparam micro_op_t init_micro_op = '0;

endpackage

//--- issue_props.sv
`timescale 1ns/1ns

module issue_props (
  input logic                 clock,
  input logic                 reset,
  input logic                 in_strobe,
  input logic                 flush,
  input logic                 queue_full,
  input issue_pkg::micro_op_t iss0_op,
  input issue_pkg::micro_op_t iss1_op
);

  logic [2:0] last_tag;

  // tag of the youngest op issued so far
  always_ff @(posedge clock) begin
    if (!reset) begin
      last_tag <= 3'd7;
    end else if (iss1_op.valid) begin
      last_tag <= iss1_op.tag;
    end else if (iss0_op.valid) begin
      last_tag <= iss0_op.tag;
    end
  end

  no_push_when_full: assert property (@(posedge clock) disable iff (!reset)
    !(in_strobe && queue_full))
    else $error("pair strobed while the queue is full");

  quiet_after_flush: assert property (@(posedge clock) disable iff (!reset)
    flush |=> !iss0_op.valid && !iss1_op.valid)
    else $error("op issued in the cycle after a flush");

  slot1_needs_slot0: assert property (@(posedge clock) disable iff (!reset)
    !(iss1_op.valid && !iss0_op.valid))
    else $error("slot 1 issued while slot 0 is empty");

  slot0_tag_order: assert property (@(posedge clock) disable iff (!reset)
    iss0_op.valid |-> iss0_op.tag == last_tag + 3'd1)
    else $error("slot 0 tag out of order");

  slot1_tag_order: assert property (@(posedge clock) disable iff (!reset)
    iss1_op.valid |-> iss1_op.tag == iss0_op.tag + 3'd1)
    else $error("slot 1 tag out of order");

endmodule

bind issue_top issue_props u_props (
  .clock      (clock),
  .reset      (reset),
  .in_strobe  (in_strobe),
  .flush      (flush),
  .queue_full (queue_full),
  .iss0_op    (iss0_op),
  .iss1_op    (iss1_op)
);

//--- issue_queue.sv
`timescale 1ns/1ns
`include "issue_cfg.svh"

module issue_queue (
  input  logic             clock,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  logic             flush,
  input  issue_pkg::pair_t push_pair,
  output issue_pkg::pair_t head_pair,
  output logic             head_valid,
  output logic             full
);

  localparam int ptr_w = $clog2(`ISSUE_QDEPTH);
  localparam int cnt_w = $clog2(`ISSUE_QDEPTH + 1);

  issue_pkg::pair_t mem [`ISSUE_QDEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign head_valid = (count != '0);
  assign full       = (count == cnt_w'(`ISSUE_QDEPTH));
  assign head_pair  = mem[rd_ptr];

  // a strobe during flush is dropped
  assign do_push = push && !full && !flush;
  assign do_pop  = pop && head_valid && !flush;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_pair;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

endmodule

//--- issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  issue_pkg::micro_op_t cand0,
  input  issue_pkg::micro_op_t cand1,
  output logic                 advance,
  output logic                 rden0a,
  output issue_pkg::reg_addr_t raddr0a,
  output logic                 rden0b,
  output issue_pkg::reg_addr_t raddr0b,
  output logic                 rden1a,
  output issue_pkg::reg_addr_t raddr1a,
  output logic                 rden1b,
  output issue_pkg::reg_addr_t raddr1b,
  output issue_pkg::micro_op_t iss0_op,
  output issue_pkg::micro_op_t iss1_op
);

  issue_pkg::load_tag_t ltag;
  issue_pkg::load_tag_t ltag_next;
  issue_pkg::micro_op_t next0;
  issue_pkg::micro_op_t next1;
  logic stall;

  function automatic logic reads_reg(issue_pkg::micro_op_t op, issue_pkg::reg_addr_t r);
    return op.valid && ((op.rden1 && op.rs1 == r) || (op.rden2 && op.rs2 == r));
  endfunction

  function automatic logic is_load(issue_pkg::micro_op_t op);
    return op.valid && op.wren && (op.kind == issue_pkg::op_load);
  endfunction

  // load result not ready yet, hold both candidates for a cycle
  assign stall   = ltag.valid && (reads_reg(cand0, ltag.rd) || reads_reg(cand1, ltag.rd));
  assign advance = !stall;

  assign next0 = stall ? issue_pkg::init_micro_op : cand0;
  assign next1 = stall ? issue_pkg::init_micro_op : cand1;

  // a pair never holds two memory ops, so at most one load here
  always_comb begin
    ltag_next = '0;
    if (is_load(next0)) begin
      ltag_next.valid = 1'b1;
      ltag_next.rd    = next0.rd;
    end else if (is_load(next1)) begin
      ltag_next.valid = 1'b1;
      ltag_next.rd    = next1.rd;
    end
  end

  // read data comes back together with the issue registers
  assign rden0a  = next0.valid && next0.rden1;
  assign raddr0a = next0.rs1;
  assign rden0b  = next0.valid && next0.rden2;
  assign raddr0b = next0.rs2;
  assign rden1a  = next1.valid && next1.rden1;
  assign raddr1a = next1.rs1;
  assign rden1b  = next1.valid && next1.rden2;
  assign raddr1b = next1.rs2;

  stage_reg #(.payload_t(issue_pkg::micro_op_t)) u_iss0 (
    .clock  (clock),
    .reset  (reset),
    .enable (1'b1),
    .clear  (flush),
    .d      (next0),
    .q      (iss0_op)
  );

  stage_reg #(.payload_t(issue_pkg::micro_op_t)) u_iss1 (
    .clock  (clock),
    .reset  (reset),
    .enable (1'b1),
    .clear  (flush),
    .d      (next1),
    .q      (iss1_op)
  );

  stage_reg #(.payload_t(issue_pkg::load_tag_t)) u_ltag (
    .clock  (clock),
    .reset  (reset),
    .enable (1'b1),
    .clear  (flush),
    .d      (ltag_next),
    .q      (ltag)
  );

endmodule

//--- issue_top.sv
`timescale 1ns/1ns

module issue_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_strobe,
  input  issue_pkg::pair_t     in_pair,
  input  logic                 flush,
  input  logic                 wb0_en,
  input  issue_pkg::reg_addr_t wb0_addr,
  input  issue_pkg::xdata_t    wb0_data,
  input  logic                 wb1_en,
  input  issue_pkg::reg_addr_t wb1_addr,
  input  issue_pkg::xdata_t    wb1_data,
  output issue_pkg::micro_op_t iss0_op,
  output issue_pkg::micro_op_t iss1_op,
  output issue_pkg::xdata_t    iss0_a,
  output issue_pkg::xdata_t    iss0_b,
  output issue_pkg::xdata_t    iss1_a,
  output issue_pkg::xdata_t    iss1_b
);

  issue_pkg::pair_t     head_pair;
  logic                 head_valid;
  logic                 queue_full;
  logic                 pop;
  issue_pkg::micro_op_t cand0;
  issue_pkg::micro_op_t cand1;
  logic                 advance;
  logic                 rden0a;
  logic                 rden0b;
  logic                 rden1a;
  logic                 rden1b;
  issue_pkg::reg_addr_t raddr0a;
  issue_pkg::reg_addr_t raddr0b;
  issue_pkg::reg_addr_t raddr1a;
  issue_pkg::reg_addr_t raddr1b;

  issue_queue u_queue (
    .clock      (clock),
    .reset      (reset),
    .push       (in_strobe),
    .pop        (pop),
    .flush      (flush),
    .push_pair  (in_pair),
    .head_pair  (head_pair),
    .head_valid (head_valid),
    .full       (queue_full)
  );

  pair_hazard u_pair (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .head_valid (head_valid),
    .advance    (advance),
    .head_pair  (head_pair),
    .cand0      (cand0),
    .cand1      (cand1),
    .pop        (pop)
  );

  issue_stage u_issue (
    .clock   (clock),
    .reset   (reset),
    .flush   (flush),
    .cand0   (cand0),
    .cand1   (cand1),
    .advance (advance),
    .rden0a  (rden0a),
    .raddr0a (raddr0a),
    .rden0b  (rden0b),
    .raddr0b (raddr0b),
    .rden1a  (rden1a),
    .raddr1a (raddr1a),
    .rden1b  (rden1b),
    .raddr1b (raddr1b),
    .iss0_op (iss0_op),
    .iss1_op (iss1_op)
  );

  register_file u_regs (
    .clock    (clock),
    .reset    (reset),
    .rden0a   (rden0a),
    .raddr0a  (raddr0a),
    .rdata0a  (iss0_a),
    .rden0b   (rden0b),
    .raddr0b  (raddr0b),
    .rdata0b  (iss0_b),
    .rden1a   (rden1a),
    .raddr1a  (raddr1a),
    .rdata1a  (iss1_a),
    .rden1b   (rden1b),
    .raddr1b  (raddr1b),
    .rdata1b  (iss1_b),
    .wb0_en   (wb0_en),
    .wb0_addr (wb0_addr),
    .wb0_data (wb0_data),
    .wb1_en   (wb1_en),
    .wb1_addr (wb1_addr),
    .wb1_data (wb1_data)
  );

endmodule

//--- pair_hazard.sv
`timescale 1ns/1ns

module pair_hazard (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 head_valid,
  input  logic                 advance,
  input  issue_pkg::pair_t     head_pair,
  output issue_pkg::micro_op_t cand0,
  output issue_pkg::micro_op_t cand1,
  output logic                 pop
);

  issue_pkg::micro_op_t s0;
  issue_pkg::micro_op_t s1;
  issue_pkg::micro_op_t held;
  logic raw;
  logic mem0;
  logic mem1;
  logic split;

  assign s0 = head_pair.slot0;
  assign s1 = head_pair.slot1;

  always_comb begin
    raw   = s0.wren && ((s1.rden1 && s1.rs1 == s0.rd) || (s1.rden2 && s1.rs2 == s0.rd));
    mem0  = (s0.kind == issue_pkg::op_load) || (s0.kind == issue_pkg::op_store);
    mem1  = (s1.kind == issue_pkg::op_load) || (s1.kind == issue_pkg::op_store);
    split = s0.valid && s1.valid &&
            (raw || (mem0 && mem1) || (s0.kind == issue_pkg::op_branch) ||
             (s0.wren && s1.wren && s0.rd == s1.rd));
  end

  always_comb begin
    cand0 = issue_pkg::init_micro_op;
    cand1 = issue_pkg::init_micro_op;
    if (held.valid) begin
      // slot 1 of a split pair goes out alone
      cand0 = held;
    end else if (head_valid) begin
      if (!s0.valid) begin
        cand0 = s1;
      end else begin
        cand0 = s0;
        if (!split) begin
          cand1 = s1;
        end
      end
    end
  end

  // the pair leaves the queue once its last slot is accepted
  assign pop = advance && head_valid && (held.valid || !split);

  stage_reg #(.payload_t(issue_pkg::micro_op_t)) u_held (
    .clock  (clock),
    .reset  (reset),
    .enable (advance && head_valid && !held.valid && split),
    .clear  (flush || (advance && held.valid)),
    .d      (s1),
    .q      (held)
  );

endmodule

//--- register_file.sv
`timescale 1ns/1ns
`include "issue_cfg.svh"

module register_file (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rden0a,
  input  issue_pkg::reg_addr_t raddr0a,
  output issue_pkg::xdata_t    rdata0a,
  input  logic                 rden0b,
  input  issue_pkg::reg_addr_t raddr0b,
  output issue_pkg::xdata_t    rdata0b,
  input  logic                 rden1a,
  input  issue_pkg::reg_addr_t raddr1a,
  output issue_pkg::xdata_t    rdata1a,
  input  logic                 rden1b,
  input  issue_pkg::reg_addr_t raddr1b,
  output issue_pkg::xdata_t    rdata1b,
  input  logic                 wb0_en,
  input  issue_pkg::reg_addr_t wb0_addr,
  input  issue_pkg::xdata_t    wb0_data,
  input  logic                 wb1_en,
  input  issue_pkg::reg_addr_t wb1_addr,
  input  issue_pkg::xdata_t    wb1_data
);

  issue_pkg::xdata_t    regs [`ISSUE_NREGS];
  logic                 rden [4];
  issue_pkg::reg_addr_t raddr [4];
  issue_pkg::xdata_t    rdata [4];

  assign rden  = '{rden0a, rden0b, rden1a, rden1b};
  assign raddr = '{raddr0a, raddr0b, raddr1a, raddr1b};

  assign rdata0a = rdata[0];
  assign rdata0b = rdata[1];
  assign rdata1a = rdata[2];
  assign rdata1b = rdata[3];

  // port 1 is written last, so it wins on the same address
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `ISSUE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb0_en && wb0_addr != '0) begin
        regs[wb0_addr] <= wb0_data;
      end
      if (wb1_en && wb1_addr != '0) begin
        regs[wb1_addr] <= wb1_data;
      end
    end
  end

  // no bypass, a read sees the array before this edge's writes
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 4; i++) begin
        rdata[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        rdata[i] <= (rden[i] && raddr[i] != '0) ? regs[raddr[i]] : '0;
      end
    end
  end

endmodule

//--- stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     enable,
  input  logic     clear,
  input  payload_t d,
  output payload_t q
);

  // clear wins over enable
  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      q <= '0;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

//--- tb_issue_top.sv
`timescale 1ns/1ns
`include "issue_cfg.svh"

module tb_issue_top;

  typedef struct packed {
    issue_pkg::micro_op_t s0;
    issue_pkg::micro_op_t s1;
    logic                 split;
    logic                 wb_en;
    issue_pkg::reg_addr_t wb_addr;
    issue_pkg::xdata_t    wb_data;
    logic                 flush;
  } entry_t;

  typedef struct packed {
    issue_pkg::micro_op_t op0;
    issue_pkg::micro_op_t op1;
    issue_pkg::xdata_t    a0;
    issue_pkg::xdata_t    b0;
    issue_pkg::xdata_t    a1;
    issue_pkg::xdata_t    b1;
  } issue_event_t;

  localparam issue_pkg::op_kind_t alu_op    = issue_pkg::op_alu;
  localparam issue_pkg::op_kind_t load_op   = issue_pkg::op_load;
  localparam issue_pkg::op_kind_t store_op  = issue_pkg::op_store;
  localparam issue_pkg::op_kind_t branch_op = issue_pkg::op_branch;

  logic                 clock;
  logic                 reset;
  logic                 in_strobe;
  issue_pkg::pair_t     in_pair;
  logic                 flush;
  logic                 wb0_en;
  issue_pkg::reg_addr_t wb0_addr;
  issue_pkg::xdata_t    wb0_data;
  logic                 wb1_en;
  issue_pkg::reg_addr_t wb1_addr;
  issue_pkg::xdata_t    wb1_data;
  issue_pkg::micro_op_t iss0_op;
  issue_pkg::micro_op_t iss1_op;
  issue_pkg::xdata_t    iss0_a;
  issue_pkg::xdata_t    iss0_b;
  issue_pkg::xdata_t    iss1_a;
  issue_pkg::xdata_t    iss1_b;

  entry_t               table_q [$];
  issue_event_t         exp_q [$];
  issue_pkg::xdata_t    model_regs [`ISSUE_NREGS];
  logic [2:0]           next_tag;
  logic                 prev_load;
  issue_pkg::reg_addr_t prev_load_rd;
  logic                 running;

  issue_top DUT (
    .clock     (clock),
    .reset     (reset),
    .in_strobe (in_strobe),
    .in_pair   (in_pair),
    .flush     (flush),
    .wb0_en    (wb0_en),
    .wb0_addr  (wb0_addr),
    .wb0_data  (wb0_data),
    .wb1_en    (wb1_en),
    .wb1_addr  (wb1_addr),
    .wb1_data  (wb1_data),
    .iss0_op   (iss0_op),
    .iss1_op   (iss1_op),
    .iss0_a    (iss0_a),
    .iss0_b    (iss0_b),
    .iss1_a    (iss1_a),
    .iss1_b    (iss1_b)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // alu and load write rd, store and branch do not
  function automatic issue_pkg::micro_op_t make_op(issue_pkg::op_kind_t kind, int rd, int rs1,
                                                   int rs2, logic r1, logic r2);
    issue_pkg::micro_op_t op;
    op       = issue_pkg::init_micro_op;
    op.valid = 1'b1;
    op.kind  = kind;
    op.rd    = issue_pkg::reg_addr_t'(rd);
    op.rs1   = issue_pkg::reg_addr_t'(rs1);
    op.rs2   = issue_pkg::reg_addr_t'(rs2);
    op.rden1 = r1;
    op.rden2 = r2;
    op.wren  = (kind == alu_op) || (kind == load_op);
    return op;
  endfunction

  // wb_addr below zero means no writeback
  // a flushed pair does not use up its tags
  task automatic add_entry(input issue_pkg::micro_op_t s0, input issue_pkg::micro_op_t s1,
                           input logic split, input int wb_addr,
                           input issue_pkg::xdata_t wb_data, input logic fl);
    entry_t e;
    e.s0      = s0;
    e.s1      = s1;
    e.s0.tag  = next_tag;
    e.s1.tag  = next_tag + 3'd1;
    e.split   = split;
    e.wb_en   = (wb_addr >= 0);
    e.wb_addr = issue_pkg::reg_addr_t'(wb_addr);
    e.wb_data = wb_data;
    e.flush   = fl;
    if (!fl) begin
      next_tag = next_tag + 3'd2;
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    add_entry(make_op(alu_op, 10, 1, 0, 1, 1), make_op(alu_op, 11, 0, 1, 1, 1), 0,
              1, 32'h1111_0001, 0);
    add_entry(make_op(alu_op, 12, 1, 2, 1, 1), make_op(alu_op, 13, 2, 1, 1, 1), 0,
              2, 32'h2222_0002, 0);
    // read after write inside the pair
    add_entry(make_op(alu_op, 3, 1, 2, 1, 1), make_op(alu_op, 14, 3, 0, 1, 1), 1,
              4, 32'h4444_0004, 0);
    add_entry(make_op(load_op, 5, 1, 0, 1, 0), make_op(store_op, 0, 2, 4, 1, 1), 1,
              -1, '0, 0);
    add_entry(make_op(branch_op, 0, 1, 2, 1, 1), make_op(alu_op, 15, 4, 2, 1, 1), 1,
              -1, '0, 0);
    add_entry(make_op(alu_op, 16, 1, 0, 1, 0), make_op(alu_op, 16, 2, 0, 1, 0), 1,
              6, 32'h6666_0006, 0);
    // slot 1 uses the load result so it splits and then stalls
    add_entry(make_op(load_op, 7, 6, 0, 1, 0), make_op(alu_op, 17, 7, 1, 1, 1), 1,
              -1, '0, 0);
    add_entry(make_op(load_op, 8, 2, 0, 1, 0), make_op(alu_op, 18, 4, 6, 1, 1), 0,
              -1, '0, 0);
    // split pair dropped by the flush before its slot 1 is held
    add_entry(make_op(load_op, 20, 1, 0, 1, 0), make_op(alu_op, 21, 20, 1, 1, 1), 1,
              -1, '0, 1);
    add_entry(make_op(alu_op, 22, 6, 4, 1, 1), make_op(store_op, 0, 1, 2, 1, 1), 0,
              9, 32'h9999_0009, 0);
    add_entry(make_op(alu_op, 23, 9, 0, 1, 1), make_op(load_op, 24, 9, 0, 1, 0), 0,
              0, 32'hdead_beef, 0);
    add_entry(make_op(store_op, 0, 0, 9, 1, 1), make_op(alu_op, 25, 4, 9, 1, 1), 0,
              4, 32'h4444_0044, 0);
    add_entry(make_op(branch_op, 0, 9, 4, 1, 1), make_op(alu_op, 27, 9, 9, 1, 1), 1,
              -1, '0, 0);
  endtask

  function automatic issue_pkg::xdata_t operand(logic en, issue_pkg::reg_addr_t r);
    return en ? model_regs[r] : '0;
  endfunction

  function automatic logic reads_from(issue_pkg::micro_op_t op, issue_pkg::reg_addr_t r);
    return op.valid && ((op.rden1 && op.rs1 == r) || (op.rden2 && op.rs2 == r));
  endfunction

  function automatic logic is_load_op(issue_pkg::micro_op_t op);
    return op.valid && op.kind == load_op;
  endfunction

  task automatic expect_issue(input issue_pkg::micro_op_t o0, input issue_pkg::micro_op_t o1);
    issue_event_t ev;
    ev.op0 = o0;
    ev.op1 = o1;
    ev.a0  = operand(o0.rden1, o0.rs1);
    ev.b0  = operand(o0.rden2, o0.rs2);
    ev.a1  = operand(o1.rden1, o1.rs1);
    ev.b1  = operand(o1.rden2, o1.rs2);
    exp_q.push_back(ev);
  endtask

  // writeback port alternates with the entry index
  task automatic apply_entry(input entry_t e, input int idx);
    @(negedge clock);
    in_strobe     = 1'b1;
    in_pair.slot0 = e.s0;
    in_pair.slot1 = e.s1;
    wb0_en        = e.wb_en && !idx[0];
    wb1_en        = e.wb_en && idx[0];
    wb0_addr      = e.wb_addr;
    wb1_addr      = e.wb_addr;
    wb0_data      = e.wb_data;
    wb1_data      = e.wb_data;
    if (e.wb_en && e.wb_addr != '0) begin
      model_regs[e.wb_addr] = e.wb_data;
    end
    if (!e.flush && e.split) begin
      expect_issue(e.s0, issue_pkg::init_micro_op);
      expect_issue(e.s1, issue_pkg::init_micro_op);
    end else if (!e.flush) begin
      expect_issue(e.s0, e.s1);
    end
    @(negedge clock);
    in_strobe = 1'b0;
    wb0_en    = 1'b0;
    wb1_en    = 1'b0;
    flush     = e.flush;
    @(negedge clock);
    flush = 1'b0;
  endtask

  task automatic check_cycle();
    issue_event_t ev;
    if (iss0_op.valid) begin
      check(exp_q.size() != 0, 1, "issue with no pending op");
      ev = exp_q.pop_front();
      check(iss0_op, ev.op0, "slot 0 op");
      check(iss1_op, ev.op1, "slot 1 op");
      check(ev.op0.rden1 ? iss0_a : '0, ev.a0, "slot 0 operand a");
      check(ev.op0.rden2 ? iss0_b : '0, ev.b0, "slot 0 operand b");
      check(ev.op1.rden1 ? iss1_a : '0, ev.a1, "slot 1 operand a");
      check(ev.op1.rden2 ? iss1_b : '0, ev.b1, "slot 1 operand b");
    end else begin
      check(iss1_op.valid, 0, "slot 1 valid without slot 0");
    end
    check(prev_load && (reads_from(iss0_op, prev_load_rd) || reads_from(iss1_op, prev_load_rd)),
          0, "load result used in the cycle after the load");
    prev_load    = is_load_op(iss0_op) || is_load_op(iss1_op);
    prev_load_rd = is_load_op(iss0_op) ? iss0_op.rd : iss1_op.rd;
  endtask

  initial begin
    prev_load    = 1'b0;
    prev_load_rd = '0;
    wait (running);
    forever begin
      @(negedge clock);
      check_cycle();
    end
  end

  initial begin
    #1;
    repeat (table_q.size() * 4 + 50) @(posedge clock);
    $display("timeout: issued ops did not drain in time");
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset     = 1'b0;
    in_strobe = 1'b0;
    in_pair   = '0;
    flush     = 1'b0;
    wb0_en    = 1'b0;
    wb0_addr  = '0;
    wb0_data  = '0;
    wb1_en    = 1'b0;
    wb1_addr  = '0;
    wb1_data  = '0;
    running   = 1'b0;
    next_tag  = '0;
    for (int i = 0; i < `ISSUE_NREGS; i++) begin
      model_regs[i] = '0;
    end
    build_table();
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    check(iss0_op.valid, 0, "slot 0 valid after reset");
    check(iss1_op.valid, 0, "slot 1 valid after reset");
    running = 1'b1;
    foreach (table_q[i]) begin
      apply_entry(table_q[i], i);
    end
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
    // nothing more may issue once the stream is done
    repeat (6) @(negedge clock);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
